/* verilog/ingress_cfg.svh */
`ifndef INGRESS_CFG_SVH
`define INGRESS_CFG_SVH

////////////////////////////////////////////////////////////
// Port layout

// Ingress ports and the bits to index them
`define INGRESS_NUM_PORTS 4
`define INGRESS_PORT_BITS 2

// Word pointer per port region, 256 words each
`define INGRESS_PTR_BITS 8
// SRAM address is port index above the pointer
`define INGRESS_ADDR_BITS 10

// Frame length in bytes
`define INGRESS_LEN_BITS 11

////////////////////////////////////////////////////////////
// Buffer depths

// Words per port in the prefetch buffer, also the frame size limit
`define INGRESS_PREFETCH_DEPTH 16
`define INGRESS_META_DEPTH 8
`define INGRESS_TAG_DEPTH 32

`endif

/* verilog/ingress_pkg.sv */
`include "ingress_cfg.svh"

package ingress_pkg;

	// Header view of the first word of a frame
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] rest;
	} frame_hdr_t;

	// First word goes to the prefetch buffer raw and to MAC capture as header
	typedef union packed {
		logic [127:0] raw;
		frame_hdr_t hdr;
	} frame_word_u;

	// One ingress port as seen in the clk_ram_ctl domain
	typedef struct packed {
		logic ready;
		logic [`INGRESS_LEN_BITS-1:0] bytelen;
		logic valid;
		logic done;
		logic [127:0] data;
	} ingress_port_t;

	// SRAM write command, high lane codeword in the upper half
	typedef struct packed {
		logic en;
		logic [`INGRESS_ADDR_BITS-1:0] addr;
		logic [143:0] data;
	} ram_wr_t;

	typedef struct packed {
		logic en;
		logic [`INGRESS_ADDR_BITS-1:0] addr;
	} ram_rd_req_t;

	typedef struct packed {
		logic valid;
		logic [143:0] data;
	} ram_rd_rsp_t;

	// Per-port status toward the fabric
	typedef struct packed {
		logic ready;
		logic [`INGRESS_LEN_BITS-1:0] bytelen;
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
	} fabric_state_t;

	typedef struct packed {
		logic valid;
		logic last;
		logic [127:0] data;
	} frame_out_t;

	// One flag pair per 64-bit lane
	typedef struct packed {
		logic [1:0] correctable;
		logic [1:0] uncorrectable;
	} fec_status_t;

	// XOR of the positions of all set bits in a (72,64) codeword
	// Bit 0 holds overall parity and takes no part
	function automatic logic [6:0] hamming_syndrome(input logic [71:0] code);
		logic [6:0] syn;
		syn = '0;
		for (int p = 1; p < 72; p++) begin
			if (code[p])
				syn ^= 7'(p);
		end
		return syn;
	endfunction

endpackage

/* verilog/secded_encoder.sv */
`timescale 1ns/1ps

module secded_encoder import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic valid_in,
	input logic [63:0] data_in,
	output logic valid_out,
	output logic [71:0] data_out
);

	logic [71:0] code;
	logic [6:0] check;

	always_comb begin
		int j;
		code = '0;
		j = 0;
		// Data fills every position that is not a power of two
		for (int p = 1; p < 72; p++) begin
			if ((p & (p - 1)) != 0) begin
				code[p] = data_in[j];
				j++;
			end
		end
		// Check bits still zero here, so syndrome gives their values
		check = hamming_syndrome(code);
		for (int k = 0; k < 7; k++)
			code[1 << k] = check[k];
		// Overall parity over the Hamming word
		code[0] = ^code[71:1];
	end

	// One cycle of latency
	always_ff @(posedge clk_ram_ctl) begin
		valid_out <= valid_in;
		data_out <= code;
	end

endmodule

/* verilog/secded_decoder.sv */
`timescale 1ns/1ps

module secded_decoder import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic valid_in,
	input logic [71:0] data_in,
	output logic valid_out,
	output logic [63:0] data_out,
	output logic correctable,
	output logic uncorrectable
);

	logic [71:0] fixed;
	logic [6:0] syn;
	logic parity;
	logic single_err;
	logic multi_err;
	logic [63:0] data;

	always_comb begin
		int j;
		syn = hamming_syndrome(data_in);
		parity = ^data_in;
		// Odd parity with a valid position is one flipped bit
		// Syndrome zero then points at the parity bit itself
		single_err = parity && (syn < 7'd72);
		// Even parity with a syndrome is a double error
		multi_err = (!parity && (syn != 7'd0)) || (parity && (syn >= 7'd72));
		fixed = data_in;
		if (single_err)
			fixed[syn] = ~fixed[syn];
		// Gather data back from the non power of two positions
		data = '0;
		j = 0;
		for (int p = 1; p < 72; p++) begin
			if ((p & (p - 1)) != 0) begin
				data[j] = fixed[p];
				j++;
			end
		end
	end

	// Flags only on real data words
	always_ff @(posedge clk_ram_ctl) begin
		valid_out <= valid_in;
		data_out <= data;
		correctable <= valid_in && single_err;
		uncorrectable <= valid_in && multi_err;
	end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input logic clk_ram_ctl,
	input logic reset,
	input logic wr,
	input logic [WIDTH-1:0] din,
	input logic rd,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic push;
	logic pop;

	// Pushes into a full FIFO and pops from an empty one are dropped
	assign push = wr && !full;
	assign pop = rd && !empty;

	// Head word falls through to the output
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (AW + 1)'(DEPTH));

	always_ff @(posedge clk_ram_ctl) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk_ram_ctl) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
		end
	end

endmodule

/* verilog/ingress_arbiter.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module ingress_arbiter import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic reset,
	input ingress_port_t [`INGRESS_NUM_PORTS-1:0] ports,
	input logic [`INGRESS_NUM_PORTS-1:0] meta_full,
	output logic [`INGRESS_NUM_PORTS-1:0] frame_start,
	output logic enc_valid,
	output frame_word_u enc_data,
	output logic [`INGRESS_ADDR_BITS-1:0] wr_addr
);

	localparam int N = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;

	logic [PB-1:0] rr_ptr;
	logic [PB-1:0] cur_port;
	logic [PB-1:0] next_port;
	logic [PB-1:0] enc_port;
	logic busy;
	logic next_valid;
	logic start_now;
	logic [`INGRESS_PTR_BITS-1:0] wr_ptr [N];

	////////////////////////////////////////////////////////////
	// Start choice

	always_comb begin
		next_valid = 1'b0;
		next_port = rr_ptr;
		// Port at the round-robin pointer goes first
		if (ports[rr_ptr].ready && !meta_full[rr_ptr]) begin
			next_valid = 1'b1;
		end else begin
			// Fall back to the highest ready port
			for (int i = 0; i < N; i++) begin
				if (ports[i].ready && !meta_full[i]) begin
					next_valid = 1'b1;
					next_port = PB'(i);
				end
			end
		end
	end

	// Start when idle or as the current frame finishes
	assign start_now = next_valid && (!busy || ports[cur_port].done);

	////////////////////////////////////////////////////////////
	// Frame scheduling and write pointers

	always_ff @(posedge clk_ram_ctl) begin
		if (reset) begin
			frame_start <= '0;
			busy <= 1'b0;
			cur_port <= '0;
			rr_ptr <= '0;
			enc_valid <= 1'b0;
			for (int i = 0; i < N; i++)
				wr_ptr[i] <= '0;
		end else begin
			// Registered start, busy covers the pulse cycle
			frame_start <= '0;
			if (start_now) begin
				frame_start[next_port] <= 1'b1;
				busy <= 1'b1;
				cur_port <= next_port;
				rr_ptr <= rr_ptr + 1'b1;
			end else if (busy && ports[cur_port].done) begin
				busy <= 1'b0;
			end
			enc_valid <= busy && ports[cur_port].valid;
			if (enc_valid)
				wr_ptr[enc_port] <= wr_ptr[enc_port] + 1'b1;
		end
	end

	// Word toward the encoders, address lines up with their output
	always_ff @(posedge clk_ram_ctl) begin
		enc_data.raw <= ports[cur_port].data;
		enc_port <= cur_port;
		wr_addr <= {enc_port, wr_ptr[enc_port]};
	end

endmodule

/* verilog/prefetch_buffer.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module prefetch_buffer (
	input logic clk_ram_ctl,
	input logic reset,
	input logic wr,
	input logic [`INGRESS_PORT_BITS-1:0] wr_port,
	input logic [127:0] wr_data,
	input logic rd,
	input logic [`INGRESS_PORT_BITS-1:0] rd_port,
	output logic [127:0] rd_data
);

	localparam int N = `INGRESS_NUM_PORTS;
	localparam int DEPTH = `INGRESS_PREFETCH_DEPTH;
	localparam int DB = $clog2(DEPTH);

	// One region of DEPTH words per port
	logic [127:0] mem [N * DEPTH];
	logic [DB-1:0] head [N];
	logic [DB-1:0] tail [N];

	// Data path, read has one cycle of latency
	always_ff @(posedge clk_ram_ctl) begin
		if (wr)
			mem[{wr_port, tail[wr_port]}] <= wr_data;
		if (rd)
			rd_data <= mem[{rd_port, head[rd_port]}];
	end

	// Per-port ring pointers
	always_ff @(posedge clk_ram_ctl) begin
		if (reset) begin
			for (int i = 0; i < N; i++) begin
				head[i] <= '0;
				tail[i] <= '0;
			end
		end else begin
			if (wr)
				tail[wr_port] <= tail[wr_port] + 1'b1;
			if (rd)
				head[rd_port] <= head[rd_port] + 1'b1;
		end
	end

endmodule

/* verilog/egress_readout.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module egress_readout import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic reset,
	input ingress_port_t [`INGRESS_NUM_PORTS-1:0] ports,
	input logic [`INGRESS_NUM_PORTS-1:0] frame_start,
	output ram_rd_req_t ram_rd_req,
	input logic rsp_valid,
	input logic dec_valid,
	input frame_word_u dec_data,
	output logic [`INGRESS_NUM_PORTS-1:0] meta_full,
	output logic [`INGRESS_PORT_BITS-1:0] pf_wr_port,
	output logic pf_rd,
	output logic [`INGRESS_PORT_BITS-1:0] pf_rd_port,
	input logic [`INGRESS_NUM_PORTS-1:0] forward_en,
	output fabric_state_t [`INGRESS_NUM_PORTS-1:0] fabric_state,
	output logic frame_out_valid,
	output logic frame_out_last
);

	localparam int N = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;
	localparam int LB = `INGRESS_LEN_BITS;
	localparam int WB = $clog2(`INGRESS_PREFETCH_DEPTH) + 1;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_PREFETCH = 3'd1;
	localparam logic [2:0] ST_WAIT = 3'd2;
	localparam logic [2:0] ST_READY = 3'd3;
	localparam logic [2:0] ST_FORWARD = 3'd4;

	logic [2:0] state [N];
	// Words requested, words returned, frame length in words
	logic [WB-1:0] req_cnt [N];
	logic [WB-1:0] ret_cnt [N];
	logic [WB-1:0] wordlen [N];
	logic [WB-1:0] pop_cnt;
	logic [`INGRESS_PTR_BITS-1:0] rd_ptr [N];
	logic [LB-1:0] len_hold [N];
	logic [LB-1:0] meta_len [N];
	logic [N-1:0] meta_empty;
	logic [N-1:0] meta_rd;
	logic [N-1:0] ready_q;
	logic [LB-1:0] bytelen_q [N];
	logic [47:0] dst_q [N];
	logic [47:0] src_q [N];
	logic pf_last;
	logic rd_want;
	logic [PB-1:0] rd_port;
	logic [PB-1:0] tag_port;

	////////////////////////////////////////////////////////////
	// Metadata FIFOs and fabric status

	for (genvar g = 0; g < N; g++) begin : g_port
		// Length is pushed once the frame is fully written
		sync_fifo #(
			.WIDTH(LB),
			.DEPTH(`INGRESS_META_DEPTH)
		) u_meta_fifo (
			.clk_ram_ctl,
			.reset,
			.wr(ports[g].done),
			.din(len_hold[g]),
			.rd(meta_rd[g]),
			.dout(meta_len[g]),
			.empty(meta_empty[g]),
			.full(meta_full[g])
		);

		assign meta_rd[g] = (state[g] == ST_IDLE) && !meta_empty[g];
		assign fabric_state[g] = '{
			ready: ready_q[g],
			bytelen: bytelen_q[g],
			dst_mac: dst_q[g],
			src_mac: src_q[g]
		};
	end

	// Port of each outstanding read, in request order
	sync_fifo #(
		.WIDTH(PB),
		.DEPTH(`INGRESS_TAG_DEPTH)
	) u_tag_fifo (
		.clk_ram_ctl,
		.reset,
		.wr(ram_rd_req.en),
		.din(ram_rd_req.addr[`INGRESS_ADDR_BITS-1 -: PB]),
		.rd(rsp_valid),
		.dout(tag_port),
		.empty(),
		.full()
	);

	// Lowest prefetching port with words left gets the read slot
	always_comb begin
		rd_want = 1'b0;
		rd_port = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (state[i] == ST_PREFETCH && req_cnt[i] != wordlen[i]) begin
				rd_want = 1'b1;
				rd_port = PB'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Readout state machines

	always_ff @(posedge clk_ram_ctl) begin
		if (reset) begin
			ram_rd_req <= '0;
			pf_rd <= 1'b0;
			pf_last <= 1'b0;
			pf_rd_port <= '0;
			pop_cnt <= '0;
			frame_out_valid <= 1'b0;
			frame_out_last <= 1'b0;
			ready_q <= '0;
			for (int i = 0; i < N; i++) begin
				state[i] <= ST_IDLE;
				req_cnt[i] <= '0;
				ret_cnt[i] <= '0;
				rd_ptr[i] <= '0;
			end
		end else begin
			ram_rd_req.en <= rd_want;
			ram_rd_req.addr <= {rd_port, rd_ptr[rd_port]};
			pf_rd <= 1'b0;
			pf_last <= 1'b0;
			// Prefetch data appears one cycle after the pop
			frame_out_valid <= pf_rd;
			frame_out_last <= pf_last;
			if (rd_want) begin
				rd_ptr[rd_port] <= rd_ptr[rd_port] + 1'b1;
				req_cnt[rd_port] <= req_cnt[rd_port] + 1'b1;
			end
			if (dec_valid)
				ret_cnt[pf_wr_port] <= ret_cnt[pf_wr_port] + 1'b1;
			for (int i = 0; i < N; i++) begin
				case (state[i])
					ST_IDLE: begin
						if (meta_rd[i]) begin
							req_cnt[i] <= '0;
							ret_cnt[i] <= '0;
							state[i] <= ST_PREFETCH;
						end
					end
					ST_PREFETCH: begin
						if (req_cnt[i] == wordlen[i])
							state[i] <= ST_WAIT;
					end
					// First word back means MACs are captured too
					ST_WAIT: begin
						if (ret_cnt[i] == wordlen[i]) begin
							ready_q[i] <= 1'b1;
							state[i] <= ST_READY;
						end
					end
					// Only one port forwards at a time, pop counter is shared
					ST_READY: begin
						if (forward_en[i]) begin
							ready_q[i] <= 1'b0;
							pf_rd <= 1'b1;
							pf_rd_port <= PB'(i);
							pf_last <= (wordlen[i] == WB'(1));
							pop_cnt <= WB'(1);
							state[i] <= ST_FORWARD;
						end
					end
					ST_FORWARD: begin
						if (pop_cnt == wordlen[i]) begin
							state[i] <= ST_IDLE;
						end else begin
							pf_rd <= 1'b1;
							pf_last <= (pop_cnt + 1'b1 == wordlen[i]);
							pop_cnt <= pop_cnt + 1'b1;
						end
					end
					default: state[i] <= ST_IDLE;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Frame metadata

	always_ff @(posedge clk_ram_ctl) begin
		// Tag lines up with the decoder output
		pf_wr_port <= tag_port;
		if (dec_valid && ret_cnt[pf_wr_port] == '0) begin
			dst_q[pf_wr_port] <= dec_data.hdr.dst_mac;
			src_q[pf_wr_port] <= dec_data.hdr.src_mac;
		end
		for (int i = 0; i < N; i++) begin
			// Port still shows its length in the start cycle
			if (frame_start[i])
				len_hold[i] <= ports[i].bytelen;
			// Byte length rounded up to whole 16-byte words
			if (meta_rd[i]) begin
				bytelen_q[i] <= meta_len[i];
				wordlen[i] <= WB'((meta_len[i] + LB'(15)) >> 4);
			end
		end
	end

endmodule

/* verilog/ingress_fifo.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module ingress_fifo import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic reset,
	input ingress_port_t [`INGRESS_NUM_PORTS-1:0] ports,
	output wire [`INGRESS_NUM_PORTS-1:0] frame_start,
	output wire ram_wr_t ram_wr,
	output wire ram_rd_req_t ram_rd_req,
	input ram_rd_rsp_t ram_rd_rsp,
	input logic [`INGRESS_NUM_PORTS-1:0] forward_en,
	output wire fabric_state_t [`INGRESS_NUM_PORTS-1:0] fabric_state,
	output wire frame_out_t frame_out,
	output wire fec_status_t fec_status
);

	wire [`INGRESS_NUM_PORTS-1:0] meta_full;
	wire enc_valid;
	wire frame_word_u enc_data;
	wire dec_valid;
	wire frame_word_u dec_data;
	wire [`INGRESS_PORT_BITS-1:0] pf_wr_port;
	wire pf_rd;
	wire [`INGRESS_PORT_BITS-1:0] pf_rd_port;

	////////////////////////////////////////////////////////////
	// Write side

	ingress_arbiter u_arbiter (
		.clk_ram_ctl,
		.reset,
		.ports,
		.meta_full,
		.frame_start,
		.enc_valid,
		.enc_data,
		.wr_addr(ram_wr.addr)
	);

	// High lane drives the write strobe
	secded_encoder u_enc_hi (
		.clk_ram_ctl,
		.valid_in(enc_valid),
		.data_in(enc_data.raw[127:64]),
		.valid_out(ram_wr.en),
		.data_out(ram_wr.data[143:72])
	);

	secded_encoder u_enc_lo (
		.clk_ram_ctl,
		.valid_in(enc_valid),
		.data_in(enc_data.raw[63:0]),
		.valid_out(),
		.data_out(ram_wr.data[71:0])
	);

	////////////////////////////////////////////////////////////
	// Read side

	secded_decoder u_dec_hi (
		.clk_ram_ctl,
		.valid_in(ram_rd_rsp.valid),
		.data_in(ram_rd_rsp.data[143:72]),
		.valid_out(dec_valid),
		.data_out(dec_data.raw[127:64]),
		.correctable(fec_status.correctable[1]),
		.uncorrectable(fec_status.uncorrectable[1])
	);

	secded_decoder u_dec_lo (
		.clk_ram_ctl,
		.valid_in(ram_rd_rsp.valid),
		.data_in(ram_rd_rsp.data[71:0]),
		.valid_out(),
		.data_out(dec_data.raw[63:0]),
		.correctable(fec_status.correctable[0]),
		.uncorrectable(fec_status.uncorrectable[0])
	);

	egress_readout u_readout (
		.clk_ram_ctl,
		.reset,
		.ports,
		.frame_start,
		.ram_rd_req,
		.rsp_valid(ram_rd_rsp.valid),
		.dec_valid,
		.dec_data,
		.meta_full,
		.pf_wr_port,
		.pf_rd,
		.pf_rd_port,
		.forward_en,
		.fabric_state,
		.frame_out_valid(frame_out.valid),
		.frame_out_last(frame_out.last)
	);

	// Every decoded word is prefetched for its port
	prefetch_buffer u_prefetch (
		.clk_ram_ctl,
		.reset,
		.wr(dec_valid),
		.wr_port(pf_wr_port),
		.wr_data(dec_data.raw),
		.rd(pf_rd),
		.rd_port(pf_rd_port),
		.rd_data(frame_out.data)
	);

endmodule

/* sim/ingress_fifo_chk.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module ingress_fifo_chk import ingress_pkg::*; (
	input logic clk_ram_ctl,
	input logic reset,
	input logic [`INGRESS_NUM_PORTS-1:0] frame_start,
	input ram_wr_t ram_wr,
	input ram_rd_req_t ram_rd_req,
	input frame_out_t frame_out,
	input fabric_state_t [`INGRESS_NUM_PORTS-1:0] fabric_state,
	input fec_status_t fec_status
);

	// Number of failed assertions, read by the testbench at the end
	int fail_count = 0;
	logic [`INGRESS_NUM_PORTS-1:0] ready_vec;

	always_comb begin
		for (int i = 0; i < `INGRESS_NUM_PORTS; i++)
			ready_vec[i] = fabric_state[i].ready;
	end

	////////////////////////////////////////////////////////////
	// Protocol rules

	// At most one port started per cycle
	a_start_onehot: assert property (@(posedge clk_ram_ctl) disable iff (reset)
		$onehot0(frame_start))
	else begin
		fail_count++;
		$error("frame_start has more than one bit set");
	end

	// last never without valid
	a_last_valid: assert property (@(posedge clk_ram_ctl) disable iff (reset)
		frame_out.last |-> frame_out.valid)
	else begin
		fail_count++;
		$error("frame_out.last without frame_out.valid");
	end

	// Quiet outputs in the first cycle out of reset
	a_reset_quiet: assert property (@(posedge clk_ram_ctl)
		$fell(reset) |-> (frame_start == '0 && !ram_wr.en && !ram_rd_req.en
			&& !frame_out.valid && !frame_out.last && ready_vec == '0
			&& fec_status == '0))
	else begin
		fail_count++;
		$error("output active right after reset");
	end

endmodule

bind ingress_fifo ingress_fifo_chk u_chk (.*);

/* sim/tb_ingress_fifo.sv */
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module tb_ingress_fifo import ingress_pkg::*; ();

	localparam int N = `INGRESS_NUM_PORTS;
	localparam int AW = `INGRESS_ADDR_BITS;
	localparam int PW = `INGRESS_PTR_BITS;

	logic clk_ram_ctl;
	logic reset;
	ingress_port_t port_drv [N];
	ingress_port_t [N-1:0] ports;
	logic [N-1:0] frame_start;
	logic [N-1:0] forward_en;
	ram_wr_t ram_wr;
	ram_rd_req_t ram_rd_req;
	ram_rd_rsp_t ram_rd_rsp;
	fabric_state_t [N-1:0] fabric_state;
	frame_out_t frame_out;
	fec_status_t fec_status;

	logic [31:0] lfsr;
	// SRAM contents and per-address fault masks
	logic [143:0] sram [1 << AW];
	logic [143:0] flip [1 << AW];
	logic [AW-1:0] rd_addr_q [$];
	longint rd_due_q [$];
	longint cyc;
	longint last_due;
	// Expected frames per port with words flat in send order
	logic [127:0] exp_words [N][$];
	int exp_len [N][$];
	int sent_cnt [N];
	int wr_cnt [N];
	logic hv1;
	logic hv2;
	logic [1:0] hp1;
	logic [1:0] hp2;
	logic [N-1:0] ready_prev;
	logic [1:0] rr_exp;
	int corr_cnt [2];
	int unc_cnt [2];
	bit skip_data;

	for (genvar g = 0; g < N; g++) begin : g_port
		assign ports[g] = port_drv[g];
	end

	ingress_fifo u_ingress_fifo (
		.clk_ram_ctl,
		.reset,
		.ports,
		.frame_start,
		.ram_wr,
		.ram_rd_req,
		.ram_rd_rsp,
		.forward_en,
		.fabric_state,
		.frame_out,
		.fec_status
	);

	initial begin
		clk_ram_ctl = 1'b0;
		forever #50 clk_ram_ctl = ~clk_ram_ctl;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	function automatic logic [127:0] rand_word();
		logic [127:0] w;
		w = '0;
		for (int i = 0; i < 4; i++)
			w = {w[95:0], rand_bits(32)};
		return w;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic timeout_abort(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	// Offer one frame on port p with an optional fault mask on one of its words
	task automatic send_frame(input int p, input int len, input logic [143:0] mask,
			input int mask_word);
		int n;
		int t;
		logic [127:0] w;
		n = (len + 15) / 16;
		exp_len[p].push_back(len);
		if (mask_word >= 0)
			flip[(p << PW) + sent_cnt[p] + mask_word] = mask;
		// Ready goes up just after a rising edge
		@(posedge clk_ram_ctl);
		#1;
		port_drv[p].ready = 1'b1;
		port_drv[p].bytelen = len;
		t = 0;
		do begin
			@(posedge clk_ram_ctl);
			#1;
			t++;
			if (t > 2000)
				timeout_abort("frame_start");
		end while (!frame_start[p]);
		// Ready drops after the pulse cycle
		@(posedge clk_ram_ctl);
		#1;
		port_drv[p].ready = 1'b0;
		for (int i = 0; i < n; i++) begin
			// Random gaps between words
			while (rand_bits(2) == 0) begin
				port_drv[p].valid = 1'b0;
				@(posedge clk_ram_ctl);
				#1;
			end
			w = rand_word();
			exp_words[p].push_back(w);
			port_drv[p].data = w;
			port_drv[p].valid = 1'b1;
			port_drv[p].done = (i == n - 1);
			@(posedge clk_ram_ctl);
			#1;
		end
		port_drv[p].valid = 1'b0;
		port_drv[p].done = 1'b0;
		sent_cnt[p] += n;
	endtask

	// Fabric model that forwards count frames one at a time
	task automatic drain_frames(input int count);
		int p;
		int t;
		int n;
		int len;
		logic [127:0] w;
		frame_hdr_t hdr;
		repeat (count) begin
			t = 0;
			p = -1;
			while (p < 0) begin
				@(posedge clk_ram_ctl);
				#1;
				t++;
				if (t > 5000)
					timeout_abort("a fabric_state ready");
				for (int i = N - 1; i >= 0; i--) begin
					if (fabric_state[i].ready)
						p = i;
				end
			end
			len = exp_len[p].pop_front();
			n = (len + 15) / 16;
			hdr = frame_hdr_t'(exp_words[p][0]);
			assert (fabric_state[p].bytelen == len)
			else report_error($sformatf("port %0d bytelen %0d, expected %0d", p,
				fabric_state[p].bytelen, len));
			assert (fabric_state[p].dst_mac == hdr.dst_mac &&
					fabric_state[p].src_mac == hdr.src_mac)
			else report_error($sformatf("port %0d MAC addresses differ", p));
			forward_en[p] = 1'b1;
			@(posedge clk_ram_ctl);
			#1;
			forward_en = '0;
			@(negedge clk_ram_ctl);
			assert (!frame_out.valid && !fabric_state[p].ready)
			else report_error("frame_out too early or ready still high");
			// Stream on consecutive cycles
			for (int i = 0; i < n; i++) begin
				@(negedge clk_ram_ctl);
				w = exp_words[p].pop_front();
				assert (frame_out.valid && frame_out.last == (i == n - 1))
				else report_error($sformatf("port %0d word %0d valid or last wrong", p, i));
				if (!skip_data)
					assert (frame_out.data == w)
					else report_error($sformatf("port %0d word %0d data %h, expected %h",
						p, i, frame_out.data, w));
			end
			@(negedge clk_ram_ctl);
			assert (!frame_out.valid)
			else report_error("frame_out longer than the frame");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitors and SRAM model

	always @(negedge clk_ram_ctl) begin : monitor
		int exp_p;
		longint due;
		if (reset) begin
			hv1 = 1'b0;
			hv2 = 1'b0;
			rr_exp = '0;
			ready_prev = '0;
			for (int i = 0; i < N; i++)
				wr_cnt[i] = 0;
		end else begin
			// Write two cycles after the port word
			assert (ram_wr.en == hv2)
			else report_error("ram_wr.en not two cycles after a port word");
			if (ram_wr.en) begin
				assert (ram_wr.addr[AW-1 -: 2] == hp2 && ram_wr.addr[PW-1:0] == PW'(wr_cnt[hp2]))
				else report_error($sformatf("write address %h wrong", ram_wr.addr));
				sram[ram_wr.addr] = ram_wr.data;
				wr_cnt[hp2]++;
			end
			hv2 = hv1;
			hp2 = hp1;
			hv1 = 1'b0;
			for (int i = 0; i < N; i++) begin
				if (port_drv[i].valid) begin
					hv1 = 1'b1;
					hp1 = 2'(i);
				end
			end
			// Round-robin pointer first or else the highest ready port
			if (frame_start != '0) begin
				exp_p = rr_exp;
				if (!ready_prev[rr_exp]) begin
					for (int i = 0; i < N; i++) begin
						if (ready_prev[i])
							exp_p = i;
					end
				end
				assert (frame_start == N'(1 << exp_p))
				else report_error($sformatf("frame_start %b, expected port %0d",
					frame_start, exp_p));
				rr_exp++;
			end
			for (int i = 0; i < N; i++)
				ready_prev[i] = port_drv[i].ready;
			// Reads answer in order 3 to 6 cycles later
			if (ram_rd_req.en) begin
				due = cyc + 3 + rand_bits(2);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				rd_addr_q.push_back(ram_rd_req.addr);
				rd_due_q.push_back(due);
			end
			for (int l = 0; l < 2; l++) begin
				corr_cnt[l] += fec_status.correctable[l];
				unc_cnt[l] += fec_status.uncorrectable[l];
			end
		end
	end

	always @(posedge clk_ram_ctl) begin
		#1;
		cyc++;
		ram_rd_rsp = '0;
		if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
			void'(rd_due_q.pop_front());
			ram_rd_rsp.valid = 1'b1;
			ram_rd_rsp.data = sram[rd_addr_q[0]] ^ flip[rd_addr_q[0]];
			void'(rd_addr_q.pop_front());
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main
		int lens [8];
		int c1;
		int c0;
		int u0;
		lfsr = 32'h41bb8b06;
		reset = 1'b1;
		forward_en = '0;
		ram_rd_rsp = '0;
		skip_data = 1'b0;
		cyc = 0;
		last_due = 0;
		for (int i = 0; i < N; i++) begin
			port_drv[i] = '0;
			sent_cnt[i] = 0;
		end
		for (int a = 0; a < (1 << AW); a++)
			flip[a] = '0;
		for (int l = 0; l < 2; l++) begin
			corr_cnt[l] = 0;
			unc_cnt[l] = 0;
		end
		repeat (5) @(posedge clk_ram_ctl);
		#1;
		reset = 1'b0;

		// Quiet until the first frame
		repeat (8) begin
			@(negedge clk_ram_ctl);
			assert (frame_start == '0 && !ram_wr.en && !ram_rd_req.en && !frame_out.valid
					&& fabric_state[0].ready == 0 && fabric_state[1].ready == 0
					&& fabric_state[2].ready == 0 && fabric_state[3].ready == 0)
			else report_error("output active before any frame");
		end
		@(posedge clk_ram_ctl);
		#1;

		// Single frame on one port
		fork
			send_frame(1, 50, '0, -1);
			drain_frames(1);
		join

		// All ports at once with two frames each
		for (int i = 0; i < 8; i++)
			lens[i] = 1 + rand_bits(8);
		fork
			begin
				send_frame(0, lens[0], '0, -1);
				send_frame(0, lens[1], '0, -1);
			end
			begin
				send_frame(1, lens[2], '0, -1);
				send_frame(1, lens[3], '0, -1);
			end
			begin
				send_frame(2, lens[4], '0, -1);
				send_frame(2, lens[5], '0, -1);
			end
			begin
				send_frame(3, lens[6], '0, -1);
				send_frame(3, lens[7], '0, -1);
			end
			drain_frames(8);
		join

		// Single bit flip in the high lane of the first word
		c1 = corr_cnt[1];
		c0 = corr_cnt[0];
		fork
			send_frame(2, 64, 144'(1) << 77, 0);
			drain_frames(1);
		join
		assert (corr_cnt[1] == c1 + 1 && corr_cnt[0] == c0 && unc_cnt[0] == 0 && unc_cnt[1] == 0)
		else report_error("correctable flag count wrong after single bit flip");

		// Two flips in the low lane of the second word
		skip_data = 1'b1;
		u0 = unc_cnt[0];
		fork
			send_frame(0, 40, (144'(1) << 3) | (144'(1) << 40), 1);
			drain_frames(1);
		join
		skip_data = 1'b0;
		assert (unc_cnt[0] == u0 + 1 && unc_cnt[1] == 0)
		else report_error("uncorrectable flag count wrong after double bit flip");

		// Pointer now sits on idle port 3 so the higher of two ready ports wins
		lens[0] = 1 + rand_bits(8);
		lens[1] = 1 + rand_bits(8);
		fork
			send_frame(0, lens[0], '0, -1);
			send_frame(1, lens[1], '0, -1);
			drain_frames(2);
		join

		repeat (5) @(posedge clk_ram_ctl);
		if (u_ingress_fifo.u_chk.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule

/* project.f */
+incdir+verilog
verilog/ingress_pkg.sv
verilog/secded_encoder.sv
verilog/secded_decoder.sv
verilog/sync_fifo.sv
verilog/ingress_arbiter.sv
verilog/prefetch_buffer.sv
verilog/egress_readout.sv
verilog/ingress_fifo.sv
sim/ingress_fifo_chk.sv
sim/tb_ingress_fifo.sv
